// File: all.f
ooo_pkg.sv
map_table.sv
rob.sv
rs_entry.sv
rs.sv
alu_stage.sv
ooo_core.sv
tb_ooo_core.sv

// File: alu_stage.sv
//////////////////////////////////////////////////
// single-cycle execute stage, result registered onto the cdb
//////////////////////////////////////////////////
`timescale 1ns/10ps

module alu_stage (
    input  logic                   clock,
    input  logic                   reset,
    input  ooo_pkg::issue_packet_t issue,
    output ooo_pkg::cdb_packet_t   cdb
);
    ooo_pkg::data_t result;

    always_comb begin
        case (issue.op)
            ooo_pkg::op_li:  result = issue.opa;   // imm passed through
            ooo_pkg::op_add: result = issue.opa + issue.opb;
            ooo_pkg::op_sub: result = issue.opa - issue.opb;
            ooo_pkg::op_and: result = issue.opa & issue.opb;
            ooo_pkg::op_or:  result = issue.opa | issue.opb;
            ooo_pkg::op_xor: result = issue.opa ^ issue.opb;
            default:         result = '0;          // unused codes
        endcase
    end

    // one broadcast per cycle, never stalls
    always_ff @(posedge clock) begin
        if (reset) cdb.valid <= 1'b0;
        else       cdb.valid <= issue.valid;
        cdb.tag   <= issue.tag;
        cdb.value <= result;
    end

endmodule

// File: map_table.sv
//////////////////////////////////////////////////
// register map table: value or producer tag per register
// renames dest at dispatch, reads sources with cdb bypass
//////////////////////////////////////////////////
`timescale 1ns/10ps

module map_table (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_fire,
    input  ooo_pkg::dispatch_packet_t dispatch,
    input  ooo_pkg::rob_tag_t         alloc_tag,
    input  ooo_pkg::cdb_packet_t      cdb,
    output ooo_pkg::operand_t         src1,
    output ooo_pkg::operand_t         src2
);
    localparam int num_regs = 2 ** $bits(ooo_pkg::arch_reg_t);

    logic              reg_ready [num_regs];      // value present
    ooo_pkg::rob_tag_t reg_tag   [num_regs];      // latest producer
    ooo_pkg::data_t    reg_value [num_regs];

    // current state of one register, plus same-cycle cdb hit
    function automatic ooo_pkg::operand_t lookup(input ooo_pkg::arch_reg_t r);
        ooo_pkg::operand_t opnd;
        opnd.ready = reg_ready[r];
        opnd.tag   = reg_tag[r];
        opnd.value = reg_value[r];
        if (!reg_ready[r] && cdb.valid && (cdb.tag == reg_tag[r])) begin
            opnd.ready = 1'b1;                     // bypass
            opnd.value = cdb.value;
        end
        return opnd;
    endfunction

    // read before rename, so src == dest sees the old producer
    always_comb begin
        src1 = lookup(dispatch.src1);
        src2 = lookup(dispatch.src2);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                reg_ready[i] <= 1'b1;
                reg_tag[i]   <= '0;
                reg_value[i] <= '0;
            end
        end else begin
            // capture only while still waiting on that exact tag
            for (int i = 0; i < num_regs; i++) begin
                if (cdb.valid && !reg_ready[i] && (reg_tag[i] == cdb.tag)) begin
                    reg_ready[i] <= 1'b1;
                    reg_value[i] <= cdb.value;
                end
            end
            if (dispatch_fire) begin               // later rename wins
                reg_ready[dispatch.dest] <= 1'b0;
                reg_tag[dispatch.dest]   <= alloc_tag;
            end
        end
    end

endmodule

// File: ooo_core.sv
//////////////////////////////////////////////////
// top of the core slice: dispatch in, commit out
// map table, rob, rs and alu joined by the cdb
//////////////////////////////////////////////////
`timescale 1ns/10ps

module ooo_core #(
    parameter int rs_depth  = 4,
    parameter int rob_depth = 8
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_valid,
    input  ooo_pkg::dispatch_packet_t dispatch,
    output logic                      dispatch_ready,
    output ooo_pkg::commit_packet_t   commit
);
    logic                   dispatch_fire;
    logic                   rs_free;
    logic                   rob_full;
    ooo_pkg::rob_tag_t      alloc_tag;
    ooo_pkg::rob_tag_t      rob_head;
    ooo_pkg::operand_t      src1;
    ooo_pkg::operand_t      src2;
    ooo_pkg::issue_packet_t issue;
    ooo_pkg::cdb_packet_t   cdb;

    // back-pressure only here
    assign dispatch_ready = rs_free && !rob_full;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    map_table i_map_table (
        .clock         (clock),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .dispatch      (dispatch),
        .alloc_tag     (alloc_tag),
        .cdb           (cdb),
        .src1          (src1),
        .src2          (src2)
    );

    rob #(.rob_depth(rob_depth)) i_rob (
        .clock         (clock),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .dest          (dispatch.dest),
        .cdb           (cdb),
        .alloc_tag     (alloc_tag),
        .rob_full      (rob_full),
        .rob_head      (rob_head),
        .commit        (commit)
    );

    rs #(.rs_depth(rs_depth)) i_rs (
        .clock         (clock),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .dispatch      (dispatch),
        .alloc_tag     (alloc_tag),
        .src1          (src1),
        .src2          (src2),
        .cdb           (cdb),
        .rob_head      (rob_head),
        .rs_free       (rs_free),
        .issue         (issue)
    );

    alu_stage i_alu (
        .clock (clock),
        .reset (reset),
        .issue (issue),
        .cdb   (cdb)
    );

endmodule

// File: ooo_pkg.sv
//////////////////////////////////////////////////
// shared types and packets for the out-of-order core slice
// every stage refers to these by ooo_pkg:: scoped names
//////////////////////////////////////////////////

package ooo_pkg;

    parameter int xlen = 32;                      // datapath width

    typedef logic [xlen-1:0] data_t;              // operand / result word
    typedef logic [2:0]      arch_reg_t;          // 8 architectural regs
    typedef logic [3:0]      rob_tag_t;           // rob index, depth <= 16
    typedef logic [2:0]      alu_op_t;

    //////////////////////////////////////////////////
    // operation codes
    //////////////////////////////////////////////////
    localparam alu_op_t op_li  = 3'd0;            // dest = imm
    localparam alu_op_t op_add = 3'd1;
    localparam alu_op_t op_sub = 3'd2;            // wraps
    localparam alu_op_t op_and = 3'd3;
    localparam alu_op_t op_or  = 3'd4;
    localparam alu_op_t op_xor = 3'd5;

    //////////////////////////////////////////////////
    // packets between stages
    //////////////////////////////////////////////////

    // decoded instruction at the dispatch port
    typedef struct packed {
        alu_op_t   op;
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;                          // unused by li
        data_t     imm;                           // li only
    } dispatch_packet_t;

    // source operand, either a value or a pending tag
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;                            // producer when not ready
        data_t    value;
    } operand_t;

    // rs -> execute
    typedef struct packed {
        logic     valid;
        alu_op_t  op;
        rob_tag_t tag;
        data_t    opa;
        data_t    opb;
    } issue_packet_t;

    // result broadcast
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    value;
    } cdb_packet_t;

    // in-order retirement record
    typedef struct packed {
        logic      valid;
        arch_reg_t dest;
        data_t     value;
    } commit_packet_t;

endpackage

// File: rob.sv
//////////////////////////////////////////////////
// circular reorder buffer
// hands out tags at the tail, retires done entries at the head
//////////////////////////////////////////////////
`timescale 1ns/10ps

module rob #(
    parameter int rob_depth = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    dispatch_fire,
    input  ooo_pkg::arch_reg_t      dest,
    input  ooo_pkg::cdb_packet_t    cdb,
    output ooo_pkg::rob_tag_t       alloc_tag,
    output logic                    rob_full,
    output ooo_pkg::rob_tag_t       rob_head,
    output ooo_pkg::commit_packet_t commit
);
    localparam int idx_w = (rob_depth > 1) ? $clog2(rob_depth) : 1;
    localparam ooo_pkg::rob_tag_t last_tag = ooo_pkg::rob_tag_t'(rob_depth - 1);

    ooo_pkg::arch_reg_t dest_q  [rob_depth];
    logic               done_q  [rob_depth];      // result captured
    ooo_pkg::data_t     value_q [rob_depth];

    ooo_pkg::rob_tag_t                  head;
    ooo_pkg::rob_tag_t                  tail;
    logic [$bits(ooo_pkg::rob_tag_t):0] count;    // 0 .. rob_depth
    logic                               retire;

    function automatic ooo_pkg::rob_tag_t next_ptr(input ooo_pkg::rob_tag_t ptr);
        return (ptr == last_tag) ? '0 : ptr + 1'b1;
    endfunction

    assign alloc_tag = tail;
    assign rob_head  = head;
    assign rob_full  = (count == rob_depth);

    // head goes out as soon as it is done, no stall
    always_comb begin
        commit.valid = (count != '0) && done_q[head[idx_w-1:0]];
        commit.dest  = dest_q[head[idx_w-1:0]];
        commit.value = value_q[head[idx_w-1:0]];
    end
    assign retire = commit.valid;

    //////////////////////////////////////////////////
    // pointers, count, done bits
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_depth; i++) done_q[i] <= 1'b0;
        end else begin
            if (cdb.valid) done_q[cdb.tag[idx_w-1:0]] <= 1'b1;
            if (dispatch_fire) begin
                done_q[tail[idx_w-1:0]] <= 1'b0;   // fresh entry waits
                tail <= next_ptr(tail);
            end
            if (retire) head <= next_ptr(head);
            case ({dispatch_fire, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // none or both
            endcase
        end
    end

    // payload
    always_ff @(posedge clock) begin
        if (dispatch_fire) dest_q[tail[idx_w-1:0]] <= dest;
        if (cdb.valid) value_q[cdb.tag[idx_w-1:0]] <= cdb.value;
    end

endmodule

// File: rs.sv
//////////////////////////////////////////////////
// reservation station: array of rs_entry slots
// first-free allocation, oldest-ready issue from rob head
//////////////////////////////////////////////////
`timescale 1ns/10ps

module rs #(
    parameter int rs_depth = 4
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_fire,
    input  ooo_pkg::dispatch_packet_t dispatch,
    input  ooo_pkg::rob_tag_t         alloc_tag,
    input  ooo_pkg::operand_t         src1,
    input  ooo_pkg::operand_t         src2,
    input  ooo_pkg::cdb_packet_t      cdb,
    input  ooo_pkg::rob_tag_t         rob_head,
    output logic                      rs_free,
    output ooo_pkg::issue_packet_t    issue
);
    logic [rs_depth-1:0]    slot_load;
    logic [rs_depth-1:0]    slot_clear;
    logic [rs_depth-1:0]    slot_busy;
    logic [rs_depth-1:0]    slot_ready;
    ooo_pkg::issue_packet_t slot_entry [rs_depth];
    ooo_pkg::operand_t      opa;
    ooo_pkg::operand_t      opb;

    //////////////////////////////////////////////////
    // operand forming
    //////////////////////////////////////////////////
    always_comb begin
        opa = src1;
        opb = src2;
        if (dispatch.op == ooo_pkg::op_li) begin   // no sources, imm goes in opa
            opa.ready = 1'b1;
            opa.tag   = '0;
            opa.value = dispatch.imm;
            opb.ready = 1'b1;
            opb.tag   = '0;
            opb.value = '0;
        end
    end

    for (genvar g = 0; g < rs_depth; g++) begin : g_slot
        rs_entry i_entry (
            .clock (clock),
            .reset (reset),
            .load  (slot_load[g]),
            .clear (slot_clear[g]),
            .op    (dispatch.op),
            .tag   (alloc_tag),
            .opa   (opa),
            .opb   (opb),
            .cdb   (cdb),
            .busy  (slot_busy[g]),
            .ready (slot_ready[g]),
            .entry (slot_entry[g])
        );
    end

    //////////////////////////////////////////////////
    // issue select, smallest distance from head
    //////////////////////////////////////////////////
    // tag - head in tag width keeps program order for any depth <= 16
    always_comb begin
        ooo_pkg::rob_tag_t age;
        ooo_pkg::rob_tag_t best_age;
        issue      = '0;
        slot_clear = '0;
        best_age   = '1;
        for (int i = 0; i < rs_depth; i++) begin
            age = slot_entry[i].tag - rob_head;
            if (slot_ready[i] && (!issue.valid || (age < best_age))) begin
                issue         = slot_entry[i];     // valid rides along
                best_age      = age;
                slot_clear    = '0;
                slot_clear[i] = 1'b1;
            end
        end
    end

    // first slot that is empty or being vacated by issue
    always_comb begin
        slot_load = '0;
        rs_free   = 1'b0;
        for (int i = 0; i < rs_depth; i++) begin
            if (!rs_free && (!slot_busy[i] || slot_clear[i])) begin
                slot_load[i] = dispatch_fire;
                rs_free      = 1'b1;
            end
        end
    end

endmodule

// File: rs_entry.sv
//////////////////////////////////////////////////
// one reservation station slot
// holds an op until both operands arrive from the cdb
//////////////////////////////////////////////////
`timescale 1ns/10ps

module rs_entry (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   load,          // dispatch into this slot
    input  logic                   clear,         // issued this cycle
    input  ooo_pkg::alu_op_t       op,
    input  ooo_pkg::rob_tag_t      tag,
    input  ooo_pkg::operand_t      opa,
    input  ooo_pkg::operand_t      opb,
    input  ooo_pkg::cdb_packet_t   cdb,
    output logic                   busy,
    output logic                   ready,
    output ooo_pkg::issue_packet_t entry
);
    ooo_pkg::alu_op_t  op_q;
    ooo_pkg::rob_tag_t tag_q;
    ooo_pkg::operand_t opa_q;
    ooo_pkg::operand_t opb_q;

    // tag match against the broadcast
    function automatic ooo_pkg::operand_t wake(input ooo_pkg::operand_t o);
        ooo_pkg::operand_t w;
        w = o;
        if (!o.ready && cdb.valid && (cdb.tag == o.tag)) begin
            w.ready = 1'b1;
            w.value = cdb.value;
        end
        return w;
    endfunction

    always_ff @(posedge clock) begin
        if (reset)      busy <= 1'b0;
        else if (load)  busy <= 1'b1;              // refill beats clear
        else if (clear) busy <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (load) begin
            op_q  <= op;
            tag_q <= tag;
            opa_q <= opa;                          // already bypassed upstream
            opb_q <= opb;
        end else begin
            opa_q <= wake(opa_q);
            opb_q <= wake(opb_q);
        end
    end

    assign ready = busy && opa_q.ready && opb_q.ready;

    always_comb begin
        entry.valid = ready;
        entry.op    = op_q;
        entry.tag   = tag_q;
        entry.opa   = opa_q.value;
        entry.opb   = opb_q.value;
    end

endmodule

// File: run.sh
#!/bin/sh
# compile and run the ooo_core testbench with verilator
# exits non-zero if the build, the run or the log check fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ooo_core \
    -f all.f -o sim_ooo_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_ooo_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0

// File: tb_ooo_core.sv
//////////////////////////////////////////////////
// directed testbench for ooo_core
// sequential register model predicts each commit
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_ooo_core;
    localparam int wait_limit = 500;              // cycles per wait loop

    logic                      clock;
    logic                      reset;
    logic                      dispatch_valid;
    ooo_pkg::dispatch_packet_t dispatch;
    logic                      dispatch_ready;
    ooo_pkg::commit_packet_t   commit;

    ooo_pkg::data_t     model_regs  [8];          // architectural state
    ooo_pkg::arch_reg_t exp_dest_q  [$];          // program order
    ooo_pkg::data_t     exp_value_q [$];
    int                 errors;
    int                 tests_run;
    int                 commit_count;
    logic               ready_dropped;
    int                 seed;

    ooo_core #(.rs_depth(4), .rob_depth(8)) i_dut (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .commit         (commit)
    );

    always #4 clock = ~clock;                     // 8 ns period

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic ooo_pkg::data_t expected_result(input ooo_pkg::alu_op_t op,
                                                       input ooo_pkg::data_t a,
                                                       input ooo_pkg::data_t b,
                                                       input ooo_pkg::data_t imm);
        case (op)
            ooo_pkg::op_li:  return imm;
            ooo_pkg::op_add: return a + b;
            ooo_pkg::op_sub: return a - b;        // wraps mod 2^32
            ooo_pkg::op_and: return a & b;
            ooo_pkg::op_or:  return a | b;
            default:         return a ^ b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error: %s", msg);
        errors++;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) $display("%s: ok", name);
        else $display("%s: FAILED with %0d errors", name, errors - errs_before);
    endtask

    // model first, then hold valid until the core takes it
    task automatic dispatch_op(input ooo_pkg::alu_op_t op, input ooo_pkg::arch_reg_t dest,
                               input ooo_pkg::arch_reg_t src1,
                               input ooo_pkg::arch_reg_t src2, input ooo_pkg::data_t imm);
        int             waited;
        ooo_pkg::data_t result;
        result = expected_result(op, model_regs[src1], model_regs[src2], imm);
        model_regs[dest] = result;
        exp_dest_q.push_back(dest);
        exp_value_q.push_back(result);
        dispatch.op    = op;
        dispatch.dest  = dest;
        dispatch.src1  = src1;
        dispatch.src2  = src2;
        dispatch.imm   = imm;
        dispatch_valid = 1'b1;
        waited = 0;
        while (!dispatch_ready && waited < wait_limit) begin
            ready_dropped = 1'b1;                 // back-pressure seen
            @(negedge clock);
            waited++;
        end
        if (!dispatch_ready) report_failure("dispatch was never accepted by the core");
        @(negedge clock);                         // transfer at the rising edge
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_dest_q.size() != 0 && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (exp_dest_q.size() != 0) begin
            report_failure("commits stopped with instructions still outstanding");
            exp_dest_q.delete();
            exp_value_q.delete();
        end
    endtask

    // commit is stable between edges, one retire per valid cycle
    always @(negedge clock) begin
        if (!reset && commit.valid) begin
            commit_count++;
            if (exp_dest_q.size() == 0) begin
                report_failure("commit seen with no instruction outstanding");
            end else begin
                check_value("commit.dest", 32'(commit.dest), 32'(exp_dest_q.pop_front()));
                check_value("commit.value", commit.value, exp_value_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic test_idle_after_reset();
        int errs_before;
        errs_before = errors;
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd1);
        repeat (10) begin
            check_value("commit.valid", 32'(commit.valid), 32'd0);
            @(negedge clock);
        end
        end_test("idle after reset", errs_before);
    endtask

    task automatic test_li_all_regs();
        int errs_before;
        errs_before = errors;
        for (int r = 0; r < 8; r++) begin
            dispatch_op(ooo_pkg::op_li, 3'(r), 3'd0, 3'd0, 32'hc0de_0000 | 32'(r * 17));
        end
        wait_drain();
        end_test("li to every register", errs_before);
    endtask

    task automatic test_dependent_chain();
        int errs_before;
        errs_before = errors;
        dispatch_op(ooo_pkg::op_li,  3'd1, 3'd0, 3'd0, 32'h0000_0005);
        dispatch_op(ooo_pkg::op_li,  3'd2, 3'd0, 3'd0, 32'h0000_0f03);
        dispatch_op(ooo_pkg::op_add, 3'd3, 3'd1, 3'd2, '0);    // bypass from li
        dispatch_op(ooo_pkg::op_sub, 3'd3, 3'd3, 3'd1, '0);    // src == dest
        dispatch_op(ooo_pkg::op_and, 3'd4, 3'd3, 3'd2, '0);
        dispatch_op(ooo_pkg::op_or,  3'd4, 3'd4, 3'd1, '0);
        dispatch_op(ooo_pkg::op_xor, 3'd1, 3'd1, 3'd4, '0);
        dispatch_op(ooo_pkg::op_add, 3'd1, 3'd1, 3'd1, '0);    // both srcs = dest
        dispatch_op(ooo_pkg::op_sub, 3'd0, 3'd0, 3'd1, '0);    // goes negative
        wait_drain();
        end_test("dependent chain", errs_before);
    endtask

    // serial accumulate on r1 issues every other cycle, so the rs backs up
    task automatic test_burst_backpressure();
        int errs_before;
        int count_before;
        errs_before   = errors;
        count_before  = commit_count;
        ready_dropped = 1'b0;
        for (int i = 0; i < 32; i++) begin
            if (i % 4 == 3) dispatch_op(ooo_pkg::op_li, 3'(2 + i % 5), 3'd0, 3'd0, 32'(i));
            else dispatch_op(ooo_pkg::op_add, 3'd1, 3'd1, 3'd7, '0);
        end
        wait_drain();
        repeat (10) @(negedge clock);             // stray retires land in the count
        check_value("commit count", 32'(commit_count - count_before), 32'd32);
        if (!ready_dropped) report_failure("dispatch_ready never dropped during the burst");
        end_test("burst with back-pressure", errs_before);
    endtask

    task automatic test_random_ops();
        int               errs_before;
        ooo_pkg::alu_op_t op;
        errs_before = errors;
        for (int i = 0; i < 200; i++) begin
            op = ooo_pkg::alu_op_t'($unsigned($random(seed)) % 6);
            dispatch_op(op, 3'($random(seed)), 3'($random(seed)), 3'($random(seed)),
                        $random(seed));
            if (($random(seed) & 3) == 0) @(negedge clock);  // occasional gap
        end
        wait_drain();
        end_test("random operations", errs_before);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        seed           = 32'h6a69;
        clock          = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        errors         = 0;
        tests_run      = 0;
        commit_count   = 0;
        ready_dropped  = 1'b0;
        for (int r = 0; r < 8; r++) model_regs[r] = '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_idle_after_reset();
        test_li_all_regs();
        test_dependent_chain();
        test_burst_backpressure();
        test_random_ops();

        $display("%0d tests run, %0d commits, %0d errors", tests_run, commit_count, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
